/* verilog/apu_config.svh */
`ifndef APU_CONFIG_SVH
`define APU_CONFIG_SVH

// Busy cycles between grant and result
// Legal range is 1 to 15, bounded by the timer counter width
`define APU_LAT 2

// Operands carried with each request
// Operand 0 is a, operand 1 is b, operand 2 is the MADD addend
`define APU_NARGS 3

// Latency timer counter width
// Must hold APU_LAT without wrapping
`define APU_CNT_W 4

`endif

/* verilog/apu_pkg.sv */
`include "apu_config.svh"

package apu_pkg;

  // Operand and result word
  typedef logic [31:0] apu_word_t;

  // Operand bundle as seen on the APU request port
  typedef apu_word_t [`APU_NARGS-1:0] apu_operands_t;

  // Input flags
  // Bit 0 saturate on ADD/SUB, bit 1 signed compare for SLT
  typedef logic [1:0] apu_flags_t;

  // Result flags
  // Bit 0 zero result, bit 1 signed overflow on ADD/SUB
  typedef logic [1:0] apu_rflags_t;

  // Latency timer count
  typedef logic [`APU_CNT_W-1:0] apu_cnt_t;

  // Operation encoding on apu_op
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_MUL  = 3'd2,
    OP_MADD = 3'd3,
    OP_AND  = 3'd4,
    OP_OR   = 3'd5,
    OP_XOR  = 3'd6,
    OP_SLT  = 3'd7
  } apu_op_e;

  // Issue FSM states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUSY = 2'd1,
    DONE = 2'd2
  } apu_state_e;

endpackage

/* verilog/apu_if.sv */
interface apu_if;

  // Issue handshake
  logic req;
  logic gnt;

  // Request payload, held stable by the core until grant
  apu_pkg::apu_op_e       op;
  apu_pkg::apu_operands_t operands;
  apu_pkg::apu_flags_t    flags;

  // Result side, rvalid is always accepted by the core
  logic                   rvalid;
  apu_pkg::apu_word_t     result;
  apu_pkg::apu_rflags_t   rflags;

  // Controller sees the request and owns grant and rvalid
  modport ctrl(input req, output gnt, output rvalid);

  // Datapath sees the payload and owns the result
  modport dp(input op, input operands, input flags, output result, output rflags);

endinterface

/* verilog/apu_clock_gate.sv */
module apu_clock_gate (
  input  logic clk_i,
  input  logic en_i,
  input  logic scan_cg_en_i,
  output logic clk_o
);

  // Latched enable, only changes while the clock is low
  logic en_latch;

  // Transparent in the low phase
  // Scan override forces the clock through for test
  always_latch begin
    if (!clk_i) begin
      en_latch = en_i | scan_cg_en_i;
    end
  end

  // Enable is stable for the whole high phase, no glitches
  assign clk_o = clk_i & en_latch;

endmodule

/* verilog/apu_ctrl.sv */
module apu_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  apu_if.ctrl  bus,
  input  logic done_i,
  output logic start_o,
  output logic load_o
);

  apu_pkg::apu_state_e state_q;
  apu_pkg::apu_state_e state_d;

  // Request accepted on this edge
  logic xfer;

  // Grant only when nothing is outstanding
  // Purely combinational on req, no reset gating here
  assign bus.gnt = bus.req && (state_q == apu_pkg::IDLE);

  assign xfer = bus.req && bus.gnt;

  // Datapath captures the payload on the transfer edge
  assign load_o = xfer;

  // Timer is armed on the same edge
  assign start_o = xfer;

  // Result is presented for exactly the DONE cycle
  assign bus.rvalid = (state_q == apu_pkg::DONE);

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      apu_pkg::IDLE: begin
        if (xfer) begin
          state_d = apu_pkg::BUSY;
        end
      end
      apu_pkg::BUSY: begin
        // Timer pulse closes the busy window
        if (done_i) begin
          state_d = apu_pkg::DONE;
        end
      end
      apu_pkg::DONE: begin
        // One cycle of rvalid, then ready for the next request
        state_d = apu_pkg::IDLE;
      end
      default: begin
        state_d = apu_pkg::IDLE;
      end
    endcase
  end

  // State register on the gated clock
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= apu_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* verilog/apu_lat_timer.sv */
`include "apu_config.svh"

module apu_lat_timer (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic start_i,
  output logic done_o
);

  // Remaining busy cycles, parks at zero
  apu_pkg::apu_cnt_t cnt_q;

  // Start loads the configured latency
  // done_o is registered from the count-of-one cycle, so it lands APU_LAT edges after start
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        cnt_q <= apu_pkg::apu_cnt_t'(`APU_LAT);
      end else if (cnt_q != '0) begin
        cnt_q  <= cnt_q - 1'b1;
        done_o <= (cnt_q == apu_pkg::apu_cnt_t'(1)); // single-cycle pulse
      end
    end
  end

endmodule

/* verilog/apu_datapath.sv */
module apu_datapath (
  input  logic clk_i,
  input  logic rst_n_i,
  apu_if.dp    bus,
  input  logic load_i,
  input  logic done_i
);

  // Captured request, payload only
  apu_pkg::apu_op_e    op_q;
  apu_pkg::apu_word_t  a_q;
  apu_pkg::apu_word_t  b_q;
  apu_pkg::apu_word_t  c_q;
  apu_pkg::apu_flags_t flags_q;

  // Intermediate results
  apu_pkg::apu_word_t sum;
  apu_pkg::apu_word_t diff;
  apu_pkg::apu_word_t prod;
  logic               ovf_add;
  logic               ovf_sub;
  logic               lt;

  // Final result and flags before the result register
  apu_pkg::apu_word_t res;
  logic               ovf;

  // Operands held from transfer until the done edge
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      op_q    <= bus.op;
      a_q     <= bus.operands[0];
      b_q     <= bus.operands[1];
      c_q     <= bus.operands[2];
      flags_q <= bus.flags;
    end
  end

  assign sum  = a_q + b_q;
  assign diff = a_q - b_q;
  // Low 32 bits only
  assign prod = a_q * b_q;

  // Signed overflow: result sign disagrees with what the operands allow
  assign ovf_add = (a_q[31] == b_q[31]) && (sum[31] != a_q[31]);
  assign ovf_sub = (a_q[31] != b_q[31]) && (diff[31] != a_q[31]);

  // Compare mode picked by flag bit 1
  assign lt = flags_q[1] ? ($signed(a_q) < $signed(b_q)) : (a_q < b_q);

  always_comb begin
    res = sum;
    ovf = 1'b0;
    case (op_q)
      apu_pkg::OP_ADD: begin
        ovf = ovf_add;
        res = sum;
      end
      apu_pkg::OP_SUB: begin
        ovf = ovf_sub;
        res = diff;
      end
      apu_pkg::OP_MUL:  res = prod;
      apu_pkg::OP_MADD: res = prod + c_q;
      apu_pkg::OP_AND:  res = a_q & b_q;
      apu_pkg::OP_OR:   res = a_q | b_q;
      apu_pkg::OP_XOR:  res = a_q ^ b_q;
      apu_pkg::OP_SLT:  res = {31'b0, lt};
    endcase
    // Clamp toward the sign of a, which is the overflow direction for both ADD and SUB
    if (ovf && flags_q[0]) begin
      res = a_q[31] ? 32'h8000_0000 : 32'h7fff_ffff;
    end
  end

  // Result and flags stay put through rvalid
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bus.result <= '0;
      bus.rflags <= '0;
    end else if (done_i) begin
      bus.result <= res;
      bus.rflags <= {ovf, (res == '0)};
    end
  end

endmodule

/* verilog/apu_top.sv */
module apu_top (
  // Clock and reset
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  // Clock gate control
  input  logic                   scan_cg_en_i,
  input  logic                   core_sleep_i,

  // APU request
  input  logic                   apu_req_i,
  output logic                   apu_gnt_o,
  input  apu_pkg::apu_operands_t apu_operands_i,
  input  apu_pkg::apu_op_e       apu_op_i,
  input  apu_pkg::apu_flags_t    apu_flags_i,

  // APU response
  output logic                   apu_rvalid_o,
  output apu_pkg::apu_word_t     apu_rdata_o,
  output apu_pkg::apu_rflags_t   apu_rflags_o
);

  // Gated clock for everything behind the gate
  logic clk_gated;

  // Controller to timer and datapath strobes
  logic start;
  logic done;
  logic load;

  apu_if apu_bus ();

  // Core side into the bundle
  assign apu_bus.req      = apu_req_i;
  assign apu_bus.op       = apu_op_i;
  assign apu_bus.operands = apu_operands_i;
  assign apu_bus.flags    = apu_flags_i;

  // Bundle back out to the core
  assign apu_gnt_o    = apu_bus.gnt;
  assign apu_rvalid_o = apu_bus.rvalid;
  assign apu_rdata_o  = apu_bus.result;
  assign apu_rflags_o = apu_bus.rflags;

  // Unit stops while the core sleeps
  apu_clock_gate clock_gate_i (
    .clk_i       (clk_i),
    .en_i        (!core_sleep_i),
    .scan_cg_en_i(scan_cg_en_i),
    .clk_o       (clk_gated)
  );

  apu_ctrl ctrl_i (
    .clk_i  (clk_gated),
    .rst_n_i(rst_n_i),
    .bus    (apu_bus),
    .done_i (done),
    .start_o(start),
    .load_o (load)
  );

  // Models the pipeline depth
  apu_lat_timer lat_timer_i (
    .clk_i  (clk_gated),
    .rst_n_i(rst_n_i),
    .start_i(start),
    .done_o (done)
  );

  apu_datapath datapath_i (
    .clk_i  (clk_gated),
    .rst_n_i(rst_n_i),
    .bus    (apu_bus),
    .load_i (load),
    .done_i (done)
  );

endmodule

/* dv/apu_assert.sv */
`include "apu_config.svh"

module apu_assert (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   scan_cg_en_i,
  input logic                   core_sleep_i,
  input logic                   apu_req_i,
  input logic                   apu_gnt_o,
  input apu_pkg::apu_operands_t apu_operands_i,
  input apu_pkg::apu_op_e       apu_op_i,
  input apu_pkg::apu_flags_t    apu_flags_i,
  input logic                   apu_rvalid_o,
  input apu_pkg::apu_word_t     apu_rdata_o,
  input apu_pkg::apu_rflags_t   apu_rflags_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // Failed checks so far
  int unsigned err_cnt = 0;

  // Operation outstanding, open clock edges since its transfer
  logic        busy_q;
  int unsigned edges_q;
  // Expected {overflow, zero, result} of the outstanding operation
  logic [33:0] exp_q;

  logic gate_open;
  logic xfer;

  // A sleeping core stops the edge unless scan forces the clock
  assign gate_open = !core_sleep_i || scan_cg_en_i;
  assign xfer      = apu_req_i && apu_gnt_o && gate_open;

  // Reference model, returns {overflow, zero, result}
  function automatic logic [33:0] expect_result(input apu_pkg::apu_op_e op,
    input apu_pkg::apu_word_t a, input apu_pkg::apu_word_t b,
    input apu_pkg::apu_word_t c, input apu_pkg::apu_flags_t f);
    longint      wide;
    logic [31:0] res;
    logic        ovf;
    // Exact signed sum or difference, never overflows in 64 bits
    wide = (op == apu_pkg::OP_SUB) ? longint'($signed(a)) - longint'($signed(b))
                                   : longint'($signed(a)) + longint'($signed(b));
    ovf  = 1'b0;
    case (op)
      apu_pkg::OP_ADD, apu_pkg::OP_SUB: begin
        ovf = (wide > 64'sh7fff_ffff) || (wide < -64'sh8000_0000);
        res = wide[31:0];
        // Clamp toward the side the exact value fell out of
        if (ovf && f[0]) begin
          res = (wide > 0) ? 32'h7fff_ffff : 32'h8000_0000;
        end
      end
      apu_pkg::OP_MUL:  res = a * b;
      apu_pkg::OP_MADD: res = a * b + c;
      apu_pkg::OP_AND:  res = a & b;
      apu_pkg::OP_OR:   res = a | b;
      apu_pkg::OP_XOR:  res = a ^ b;
      // SLT, signed only when flag bit 1 is set
      default:          res = {31'b0, f[1] ? ($signed(a) < $signed(b)) : (a < b)};
    endcase
    return {ovf, res == 32'h0, res};
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      edges_q <= 0;
    end else if (xfer) begin
      busy_q  <= 1'b1;
      edges_q <= 0;
      exp_q   <= expect_result(apu_op_i, apu_operands_i[0], apu_operands_i[1],
                               apu_operands_i[2], apu_flags_i);
    end else if (busy_q && gate_open) begin
      // The edge that closes the rvalid cycle ends the operation
      busy_q  <= (edges_q != `APU_LAT + 1);
      edges_q <= edges_q + 1;
    end
  end

  // Grant only with a request and nothing outstanding
  gnt_ok: assert property (@(posedge clk_i) apu_gnt_o |-> apu_req_i && !busy_q)
    else begin
      $error("mismatch at %0t: grant while busy or without request", $time);
      err_cnt++;
    end

  // rvalid only after APU_LAT+1 open edges, for one cycle, and low in reset
  rvalid_ok: assert property (@(posedge clk_i)
      apu_rvalid_o == (busy_q && edges_q == `APU_LAT + 1))
    else begin
      $error("mismatch at %0t: rvalid is %b in the wrong cycle", $time,
             $sampled(apu_rvalid_o));
      err_cnt++;
    end

  // Flags and result against the model
  result_ok: assert property (@(posedge clk_i)
      apu_rvalid_o |-> {apu_rflags_o, apu_rdata_o} == exp_q)
    else begin
      $error("mismatch at %0t: rflags/rdata %h, expected %h", $time,
             $sampled({apu_rflags_o, apu_rdata_o}), exp_q);
      err_cnt++;
    end

endmodule

bind apu_top apu_assert assert_i (.*);

/* dv/apu_tb.sv */
module apu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   scan_cg_en_i;
  logic                   core_sleep_i;
  logic                   apu_req_i;
  logic                   apu_gnt_o;
  apu_pkg::apu_operands_t apu_operands_i;
  apu_pkg::apu_op_e       apu_op_i;
  apu_pkg::apu_flags_t    apu_flags_i;
  logic                   apu_rvalid_o;
  apu_pkg::apu_word_t     apu_rdata_o;
  apu_pkg::apu_rflags_t   apu_rflags_o;
  int unsigned            seed;

  apu_top dut0 (.*);

  // 4 ns period
  always #2 clk_i = ~clk_i;

  task automatic fail_run(input string why);
    $display("TEST FAILED");
    $fatal(1, "%s", why);
  endtask

  // Stop at the first failed assertion of the bound checker
  always @(negedge clk_i) begin
    if (dut0.assert_i.err_cnt != 0) begin
      fail_run("an assertion in the checker failed");
    end
  end

  // Hold the request until granted and drop it after the transfer edge
  task automatic issue_op(input apu_pkg::apu_op_e op, input apu_pkg::apu_word_t a,
                          input apu_pkg::apu_word_t b, input apu_pkg::apu_word_t c,
                          input apu_pkg::apu_flags_t f);
    int n;
    n = 0;
    apu_req_i         = 1'b1;
    apu_op_i          = op;
    apu_operands_i[0] = a;
    apu_operands_i[1] = b;
    apu_operands_i[2] = c;
    apu_flags_i       = f;
    @(negedge clk_i);
    while (!apu_gnt_o && n < 100) begin
      n++;
      @(negedge clk_i);
    end
    if (!apu_gnt_o) begin
      fail_run("no grant within 100 cycles");
    end
    @(posedge clk_i);
    #1;
    apu_req_i = 1'b0;
  endtask

  task automatic await_result();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!apu_rvalid_o && n < 100) begin
      n++;
      @(negedge clk_i);
    end
    if (!apu_rvalid_o) begin
      fail_run("no rvalid within 100 cycles");
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic run_op(input apu_pkg::apu_op_e op, input apu_pkg::apu_word_t a,
                        input apu_pkg::apu_word_t b, input apu_pkg::apu_word_t c,
                        input apu_pkg::apu_flags_t f);
    issue_op(op, a, b, c, f);
    await_result();
  endtask

  task automatic random_op();
    issue_op(apu_pkg::apu_op_e'($urandom_range(7, 0)), $urandom, $urandom, $urandom,
             apu_pkg::apu_flags_t'($urandom_range(3, 0)));
  endtask

  // Called right after a transfer so the unit is BUSY for the whole window
  task automatic sleep_cycles(input int k, input logic scan);
    scan_cg_en_i = scan;
    core_sleep_i = 1'b1;
    repeat (k) @(posedge clk_i);
    #1;
    core_sleep_i = 1'b0;
    scan_cg_en_i = 1'b0;
  endtask

  initial begin
    seed           = $urandom(32'h22af_5f4d);
    clk_i          = 1'b0;
    rst_n_i        = 1'b0;
    scan_cg_en_i   = 1'b0;
    core_sleep_i   = 1'b0;
    apu_req_i      = 1'b0;
    apu_op_i       = apu_pkg::OP_ADD;
    apu_operands_i = '0;
    apu_flags_i    = '0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // Saturation at both limits, for ADD and SUB
    run_op(apu_pkg::OP_ADD, 32'h7fff_ffff, 32'h0000_0001, '0, 2'b01);
    run_op(apu_pkg::OP_ADD, 32'h8000_0000, 32'hffff_ffff, '0, 2'b01);
    run_op(apu_pkg::OP_SUB, 32'h8000_0000, 32'h0000_0001, '0, 2'b01);
    run_op(apu_pkg::OP_SUB, 32'h7fff_ffff, 32'hffff_ffff, '0, 2'b01);
    // Overflow flagged but wrapped
    run_op(apu_pkg::OP_ADD, 32'h7fff_ffff, 32'h0000_0001, '0, 2'b00);
    // -1 < 1 only when signed
    run_op(apu_pkg::OP_SLT, 32'hffff_ffff, 32'h0000_0001, '0, 2'b10);
    run_op(apu_pkg::OP_SLT, 32'hffff_ffff, 32'h0000_0001, '0, 2'b00);
    // Zero results
    run_op(apu_pkg::OP_XOR, 32'h1234_5678, 32'h1234_5678, '0, 2'b00);
    run_op(apu_pkg::OP_SUB, 32'h0000_0042, 32'h0000_0042, '0, 2'b01);
    // Product wraps past 32 bits before the addend
    run_op(apu_pkg::OP_MADD, 32'h0001_0000, 32'h0001_0003, 32'h5, 2'b00);
    // Bitwise AND and OR
    run_op(apu_pkg::OP_AND, 32'hf0f0_1234, 32'h0ff0_ff00, '0, 2'b00);
    run_op(apu_pkg::OP_OR, 32'hf0f0_1234, 32'h0ff0_ff00, '0, 2'b00);

    // Random operations with sleep windows on some of them
    for (int i = 0; i < 50; i++) begin
      random_op();
      if ($urandom_range(3, 0) == 0) begin
        sleep_cycles($urandom_range(5, 1), 1'b0);
      end
      await_result();
    end

    // Back-to-back requests wait out the previous result
    repeat (6) random_op();
    await_result();

    // Scan override keeps the clock running through sleep
    issue_op(apu_pkg::OP_MUL, 32'hdead_beef, 32'h0000_1234, '0, 2'b00);
    sleep_cycles(1, 1'b1);
    await_result();

    @(negedge clk_i);
    if (dut0.assert_i.err_cnt == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      fail_run("an assertion in the checker failed");
    end
  end

endmodule

/* sim.f */
+incdir+verilog
verilog/apu_pkg.sv
verilog/apu_if.sv
verilog/apu_clock_gate.sv
verilog/apu_ctrl.sv
verilog/apu_lat_timer.sv
verilog/apu_datapath.sv
verilog/apu_top.sv
dv/apu_assert.sv
dv/apu_tb.sv

/* Makefile */
TOP = apu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wno-fatal -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) +verilator+error+limit+100 2>&1 | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" sim.log; then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
